/* build.f */
verilog/cache_pkg.sv
verilog/cache_store.sv
verilog/cache_csr.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
verif/cache_sva.sv
verif/cache_tb.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, and decide on the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module cache_tb -f build.f \
	&& ./obj_dir/Vcache_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TESTS PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* verif/cache_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_sva
(
	input logic                          clk,
	input logic                          rst,
	input logic                          cpu_req,
	input logic                          cpu_ack,
	input logic                          mem_req,
	input logic                          mem_we,
	input logic [cache_pkg::addr_w-1:0]  mem_addr,
	input logic [cache_pkg::data_w-1:0]  mem_wdata,
	input logic                          mem_ack
);

	// request and payload hold until the memory acks
	mem_hold: assert property (@(posedge clk) disable iff (!rst)
		(mem_req && !mem_ack) |=> (mem_req && $stable(mem_addr) && $stable(mem_we)
		&& (!mem_we || $stable(mem_wdata))))
		else $error("memory request dropped or changed before mem_ack");

	cpu_ack_needs_req: assert property (@(posedge clk) disable iff (!rst)
		$rose(cpu_ack) |-> cpu_req)
		else $error("cpu_ack rose without cpu_req");

	// previous handshake must be fully closed
	mem_req_after_release: assert property (@(posedge clk) disable iff (!rst)
		$rose(mem_req) |-> !mem_ack)
		else $error("mem_req rose while mem_ack was still high");

endmodule

bind cache_ctrl cache_sva i_sva (.clk(clk), .rst(rst), .cpu_req(cpu_req), .cpu_ack(cpu_ack),
	.mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
	.mem_ack(mem_ack));

`default_nettype wire

/* verif/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

	localparam int n_random = 300;
	localparam int n_bypass = 40;
	localparam int n_after = 100;
	// register port accesses over the whole run
	localparam int n_csr = 17;
	localparam int n_accesses = n_random + n_bypass + n_after + n_csr;
	localparam int hit_lat = 2;
	localparam logic [31:0] seed = 32'h7b07;

	logic clk = 1'b0;
	logic rst;
	logic cpu_req;
	logic cpu_we;
	logic [cache_pkg::addr_w-1:0] cpu_addr;
	logic [cache_pkg::data_w-1:0] cpu_wdata;
	logic cpu_ack;
	logic [cache_pkg::data_w-1:0] cpu_rdata;
	logic mem_req;
	logic mem_we;
	logic [cache_pkg::addr_w-1:0] mem_addr;
	logic [cache_pkg::data_w-1:0] mem_wdata;
	logic mem_ack;
	logic [cache_pkg::data_w-1:0] mem_rdata;
	logic csr_req;
	logic csr_we;
	logic [cache_pkg::csr_sel_w-1:0] csr_sel;
	logic [cache_pkg::data_w-1:0] csr_wdata;
	logic csr_ack;
	logic [cache_pkg::data_w-1:0] csr_rdata;

	// reference model of lines, memory and predicted counts
	logic sh_valid [cache_pkg::lines];
	logic sh_dirty [cache_pkg::lines];
	logic [cache_pkg::tag_w-1:0] sh_tag [cache_pkg::lines];
	logic [cache_pkg::data_w-1:0] sh_data [cache_pkg::lines];
	logic [cache_pkg::data_w-1:0] exp_mem [1 << cache_pkg::addr_w];
	logic [31:0] pred_hits;
	logic [31:0] pred_misses;

	// memory behind the port and the transactions it served
	logic [cache_pkg::data_w-1:0] mem_image [1 << cache_pkg::addr_w];
	logic txn_we [$];
	logic [cache_pkg::addr_w-1:0] txn_addr [$];
	logic [cache_pkg::data_w-1:0] txn_data [$];

	int checks;
	int errors;
	int test_errors;

	cache_top i_dut (.*);

	always #2 clk = ~clk;

	function automatic logic [cache_pkg::data_w-1:0] fill_word(input int a);
		logic [15:0] w;
		w = a[15:0];
		return {w ^ 16'h9e37, ~w};
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		$display("test %s finished with %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	task automatic serve_memory();
		int delay;
		forever
		begin
			@(posedge clk);
			if (mem_req && !mem_ack)
			begin
				delay = $urandom_range(5, 0);
				repeat (delay) @(posedge clk);
				txn_we.push_back(mem_we);
				txn_addr.push_back(mem_addr);
				txn_data.push_back(mem_wdata);
				if (mem_we)
					mem_image[mem_addr] = mem_wdata;
				else
					mem_rdata <= mem_image[mem_addr];
				mem_ack <= 1'b1;
				do
					@(posedge clk);
				while (mem_req);
				mem_ack <= 1'b0;
			end
		end
	endtask

	// lat counts edges after the one that first samples cpu_req
	task automatic cpu_access(input logic we, input logic [cache_pkg::addr_w-1:0] addr,
		input logic [cache_pkg::data_w-1:0] wdata, output logic [cache_pkg::data_w-1:0] rdata,
		output int lat);
		cpu_req <= 1'b1;
		cpu_we <= we;
		cpu_addr <= addr;
		cpu_wdata <= wdata;
		lat = 0;
		@(posedge clk);
		do
		begin
			@(posedge clk);
			lat++;
		end
		while (!cpu_ack);
		rdata = cpu_rdata;
		cpu_req <= 1'b0;
		do
			@(posedge clk);
		while (cpu_ack);
	endtask

	task automatic csr_access(input logic we, input logic [cache_pkg::csr_sel_w-1:0] sel,
		input logic [cache_pkg::data_w-1:0] wdata, output logic [cache_pkg::data_w-1:0] rdata);
		csr_req <= 1'b1;
		csr_we <= we;
		csr_sel <= sel;
		csr_wdata <= wdata;
		do
			@(posedge clk);
		while (!csr_ack);
		rdata = csr_rdata;
		csr_req <= 1'b0;
		do
			@(posedge clk);
		while (csr_ack);
	endtask

	task automatic read_csr_expect(input string name, input logic [cache_pkg::csr_sel_w-1:0] sel,
		input logic [31:0] exp);
		logic [cache_pkg::data_w-1:0] rd;
		csr_access(1'b0, sel, 32'd0, rd);
		check(name, rd, exp);
	endtask

	task automatic run_access(input logic we, input logic [cache_pkg::addr_w-1:0] addr,
		input logic [cache_pkg::data_w-1:0] wdata, input logic cached);
		logic [cache_pkg::index_w-1:0] idx;
		logic [cache_pkg::tag_w-1:0] tag;
		logic pred_hit;
		logic e_we;
		logic [cache_pkg::data_w-1:0] exp_rdata;
		logic [cache_pkg::data_w-1:0] got;
		logic [cache_pkg::data_w-1:0] t_data;
		logic [cache_pkg::data_w-1:0] e_data;
		logic exp_we [$];
		logic [cache_pkg::addr_w-1:0] exp_addr [$];
		logic [cache_pkg::data_w-1:0] exp_wdata [$];
		int lat;
		idx = addr[cache_pkg::index_w-1:0];
		tag = addr[cache_pkg::addr_w-1:cache_pkg::index_w];
		pred_hit = cached && sh_valid[idx] && (sh_tag[idx] == tag);
		if (!cached)
		begin
			// straight to memory with lines untouched
			exp_we.push_back(we);
			exp_addr.push_back(addr);
			exp_wdata.push_back(wdata);
			exp_rdata = exp_mem[addr];
			if (we)
				exp_mem[addr] = wdata;
		end
		else
		begin
			if (pred_hit)
				pred_hits = pred_hits + 1;
			else
			begin
				pred_misses = pred_misses + 1;
				if (sh_valid[idx] && sh_dirty[idx])
				begin
					exp_we.push_back(1'b1);
					exp_addr.push_back({sh_tag[idx], idx});
					exp_wdata.push_back(sh_data[idx]);
					exp_mem[{sh_tag[idx], idx}] = sh_data[idx];
				end
				exp_we.push_back(1'b0);
				exp_addr.push_back(addr);
				exp_wdata.push_back(32'd0);
				sh_valid[idx] = 1'b1;
				sh_dirty[idx] = 1'b0;
				sh_tag[idx] = tag;
				sh_data[idx] = exp_mem[addr];
			end
			exp_rdata = sh_data[idx];
			if (we)
			begin
				sh_data[idx] = wdata;
				sh_dirty[idx] = 1'b1;
			end
		end
		cpu_access(we, addr, wdata, got, lat);
		if (pred_hit)
			check("hit_latency", 32'(lat), 32'(hit_lat));
		if (!we)
			check("cpu_rdata", got, exp_rdata);
		check("mem_txn_count", 32'(txn_we.size()), 32'(exp_we.size()));
		while ((exp_we.size() > 0) && (txn_we.size() > 0))
		begin
			e_we = exp_we.pop_front();
			check("mem_we", 32'(txn_we.pop_front()), 32'(e_we));
			check("mem_addr", 32'(txn_addr.pop_front()), 32'(exp_addr.pop_front()));
			t_data = txn_data.pop_front();
			e_data = exp_wdata.pop_front();
			if (e_we)
				check("mem_wdata", t_data, e_data);
		end
		txn_we.delete();
		txn_addr.delete();
		txn_data.delete();
	endtask

	task automatic random_access(input logic cached);
		logic [31:0] r;
		r = $urandom();
		// four tags per index keep conflicts frequent
		run_access(r[31], {{(cache_pkg::tag_w-2){1'b0}}, r[cache_pkg::index_w+1:0]},
			$urandom(), cached);
	endtask

	initial
	begin
		logic [cache_pkg::data_w-1:0] rd;
		void'($urandom(seed));
		rst <= 1'b0;
		cpu_req <= 1'b0;
		cpu_we <= 1'b0;
		cpu_addr <= '0;
		cpu_wdata <= '0;
		mem_ack <= 1'b0;
		mem_rdata <= '0;
		csr_req <= 1'b0;
		csr_we <= 1'b0;
		csr_sel <= '0;
		csr_wdata <= '0;
		foreach (mem_image[a])
		begin
			mem_image[a] = fill_word(a);
			exp_mem[a] = fill_word(a);
		end
		foreach (sh_valid[l])
		begin
			sh_valid[l] = 1'b0;
			sh_dirty[l] = 1'b0;
			sh_tag[l] = '0;
			sh_data[l] = '0;
		end
		pred_hits = '0;
		pred_misses = '0;
		checks = 0;
		errors = 0;
		test_errors = 0;
		repeat (4) @(posedge clk);
		rst <= 1'b1;
		@(posedge clk);

		check("cpu_ack", 32'(cpu_ack), 32'd0);
		check("mem_req", 32'(mem_req), 32'd0);
		check("csr_ack", 32'(csr_ack), 32'd0);
		read_csr_expect("csr_hits", cache_pkg::csr_hits, 32'd0);
		read_csr_expect("csr_misses", cache_pkg::csr_misses, 32'd0);
		read_csr_expect("csr_ctrl", cache_pkg::csr_ctrl, 32'd1);
		end_test("reset");

		repeat (n_random) random_access(1'b1);
		read_csr_expect("csr_hits", cache_pkg::csr_hits, pred_hits);
		read_csr_expect("csr_misses", cache_pkg::csr_misses, pred_misses);
		end_test("random_traffic");

		csr_access(1'b1, cache_pkg::csr_ctrl, 32'd0, rd);
		read_csr_expect("csr_ctrl", cache_pkg::csr_ctrl, 32'd0);
		repeat (n_bypass) random_access(1'b0);
		read_csr_expect("csr_hits", cache_pkg::csr_hits, pred_hits);
		read_csr_expect("csr_misses", cache_pkg::csr_misses, pred_misses);
		end_test("bypass");

		csr_access(1'b1, cache_pkg::csr_ctrl, 32'd1, rd);
		repeat (n_after) random_access(1'b1);
		read_csr_expect("csr_hits", cache_pkg::csr_hits, pred_hits);
		read_csr_expect("csr_misses", cache_pkg::csr_misses, pred_misses);
		end_test("reenable");

		csr_access(1'b1, cache_pkg::csr_hits, 32'd0, rd);
		read_csr_expect("csr_hits", cache_pkg::csr_hits, 32'd0);
		read_csr_expect("csr_misses", cache_pkg::csr_misses, pred_misses);
		csr_access(1'b1, cache_pkg::csr_misses, 32'd0, rd);
		read_csr_expect("csr_misses", cache_pkg::csr_misses, 32'd0);
		end_test("counter_clear");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial
		serve_memory();

	// budget of 40 cycles per access
	initial
	begin
		repeat (n_accesses * 40) @(posedge clk);
		$display("timeout, the run did not finish within %0d cycles", n_accesses * 40);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/cache_csr.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_csr
(
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             csr_req,
	input  logic                             csr_we,
	input  logic [cache_pkg::csr_sel_w-1:0]  csr_sel,
	input  logic [cache_pkg::data_w-1:0]     csr_wdata,
	output logic                             csr_ack,
	output logic [cache_pkg::data_w-1:0]     csr_rdata,
	output logic                             enable,
	input  logic                             hit_pulse,
	input  logic                             miss_pulse
);

	logic [cache_pkg::data_w-1:0] hits_q;
	logic [cache_pkg::data_w-1:0] misses_q;
	logic access;

	// first cycle of a request only
	assign access = csr_req && !csr_ack;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			csr_ack <= 1'b0;
			enable <= 1'b1;
			hits_q <= '0;
			misses_q <= '0;
		end
		else
		begin
			csr_ack <= csr_req;
			if (access && csr_we && (csr_sel == cache_pkg::csr_ctrl))
				enable <= csr_wdata[0];
			// a clear beats a pulse in the same cycle
			if (access && csr_we && (csr_sel == cache_pkg::csr_hits))
				hits_q <= '0;
			else if (hit_pulse && (hits_q != '1))
				hits_q <= hits_q + 1'b1;
			if (access && csr_we && (csr_sel == cache_pkg::csr_misses))
				misses_q <= '0;
			else if (miss_pulse && (misses_q != '1))
				misses_q <= misses_q + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (access && !csr_we)
		begin
			case (csr_sel)
				cache_pkg::csr_ctrl:   csr_rdata <= {{(cache_pkg::data_w-1){1'b0}}, enable};
				cache_pkg::csr_hits:   csr_rdata <= hits_q;
				cache_pkg::csr_misses: csr_rdata <= misses_q;
				default:               csr_rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
(
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           cpu_req,
	input  logic                           cpu_we,
	input  logic [cache_pkg::addr_w-1:0]   cpu_addr,
	input  logic [cache_pkg::data_w-1:0]   cpu_wdata,
	output logic                           cpu_ack,
	output logic [cache_pkg::data_w-1:0]   cpu_rdata,
	output logic                           mem_req,
	output logic                           mem_we,
	output logic [cache_pkg::addr_w-1:0]   mem_addr,
	output logic [cache_pkg::data_w-1:0]   mem_wdata,
	input  logic                           mem_ack,
	input  logic [cache_pkg::data_w-1:0]   mem_rdata,
	input  logic                           enable,
	output logic                           hit_pulse,
	output logic                           miss_pulse,
	output logic [cache_pkg::index_w-1:0]  lookup_index,
	output logic [cache_pkg::tag_w-1:0]    lookup_tag,
	input  logic                           hit,
	input  logic                           victim_dirty,
	input  logic [cache_pkg::tag_w-1:0]    victim_tag,
	input  logic [cache_pkg::data_w-1:0]   victim_data,
	output logic                           fill_en,
	output logic [cache_pkg::tag_w-1:0]    fill_tag,
	output logic [cache_pkg::data_w-1:0]   fill_data,
	output logic                           fill_dirty,
	input  logic [cache_pkg::data_w-1:0]   line_data
);

	localparam logic [2:0] s_idle        = 3'd0;
	localparam logic [2:0] s_compare     = 3'd1;
	localparam logic [2:0] s_write_back  = 3'd2;
	localparam logic [2:0] s_allocate    = 3'd3;
	localparam logic [2:0] s_bypass      = 3'd4;
	localparam logic [2:0] s_mem_release = 3'd5;
	localparam logic [2:0] s_done        = 3'd6;

	logic [2:0] state;
	// where to go once mem_ack has fallen
	logic [2:0] ret_state;
	logic first_q;
	logic [cache_pkg::addr_w-1:0] addr_q;
	logic we_q;
	logic [cache_pkg::data_w-1:0] wdata_q;

	logic accept;
	logic cmp_dirty;
	logic cmp_clean;
	logic rel_alloc;

	assign accept = (state == s_idle) && cpu_req;
	assign cmp_dirty = (state == s_compare) && !hit && victim_dirty;
	assign cmp_clean = (state == s_compare) && !hit && !victim_dirty;
	assign rel_alloc = (state == s_mem_release) && !mem_ack && (ret_state == s_allocate);

	assign lookup_index = addr_q[cache_pkg::index_w-1:0];
	assign lookup_tag = addr_q[cache_pkg::addr_w-1:cache_pkg::index_w];

	// counted at the first compare only
	assign hit_pulse = (state == s_compare) && first_q && hit;
	assign miss_pulse = (state == s_compare) && first_q && !hit;

	// write hit or refill as the read data arrives
	assign fill_en = ((state == s_compare) && hit && we_q) || ((state == s_allocate) && mem_ack);
	assign fill_tag = lookup_tag;
	assign fill_data = we_q ? wdata_q : mem_rdata;
	assign fill_dirty = we_q;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= s_idle;
			ret_state <= s_idle;
			first_q <= 1'b0;
			cpu_ack <= 1'b0;
			mem_req <= 1'b0;
			mem_we <= 1'b0;
		end
		else
		begin
			case (state)
				s_idle:
				begin
					if (cpu_req && enable)
					begin
						first_q <= 1'b1;
						state <= s_compare;
					end
					else if (cpu_req)
					begin
						mem_req <= 1'b1;
						mem_we <= cpu_we;
						state <= s_bypass;
					end
				end
				s_compare:
				begin
					first_q <= 1'b0;
					if (hit)
					begin
						cpu_ack <= 1'b1;
						state <= s_done;
					end
					else
					begin
						// dirty victim goes out before the refill
						mem_req <= 1'b1;
						mem_we <= victim_dirty;
						state <= victim_dirty ? s_write_back : s_allocate;
					end
				end
				s_write_back, s_allocate, s_bypass:
				begin
					if (mem_ack)
					begin
						mem_req <= 1'b0;
						state <= s_mem_release;
						if (state == s_write_back)
							ret_state <= s_allocate;
						else if (state == s_allocate)
							ret_state <= s_compare;
						else
							ret_state <= s_done;
					end
				end
				s_mem_release:
				begin
					if (!mem_ack)
					begin
						if (ret_state == s_allocate)
						begin
							mem_req <= 1'b1;
							mem_we <= 1'b0;
						end
						else if (ret_state == s_done)
							cpu_ack <= 1'b1;
						state <= ret_state;
					end
				end
				s_done:
				begin
					if (!cpu_req)
					begin
						cpu_ack <= 1'b0;
						state <= s_idle;
					end
				end
				default:
					state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			addr_q <= cpu_addr;
			we_q <= cpu_we;
			wdata_q <= cpu_wdata;
		end
		if (accept && !enable)
		begin
			mem_addr <= cpu_addr;
			mem_wdata <= cpu_wdata;
		end
		else if (cmp_dirty)
		begin
			mem_addr <= {victim_tag, lookup_index};
			mem_wdata <= victim_data;
		end
		else if (cmp_clean || rel_alloc)
			mem_addr <= addr_q;
		if ((state == s_compare) && hit && !we_q)
			cpu_rdata <= line_data;
		else if ((state == s_bypass) && mem_ack && !we_q)
			cpu_rdata <= mem_rdata;
	end

endmodule

`default_nettype wire

/* verilog/cache_pkg.sv */
`default_nettype none

package cache_pkg;

	// word address without byte offset
	localparam int addr_w = 16;

	// cpu, memory and register data words
	localparam int data_w = 32;

	// direct mapped with one word per line
	localparam int index_w = 4;
	localparam int tag_w = addr_w - index_w;
	localparam int lines = 1 << index_w;

	// register port select
	localparam int csr_sel_w = 2;

	// enable bit in bit 0
	localparam logic [csr_sel_w-1:0] csr_ctrl = 2'd0;

	// hit counter cleared by a write
	localparam logic [csr_sel_w-1:0] csr_hits = 2'd1;

	// miss counter cleared by a write
	localparam logic [csr_sel_w-1:0] csr_misses = 2'd2;

endpackage

`default_nettype wire

/* verilog/cache_store.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_store
(
	input  logic                           clk,
	input  logic                           rst,
	input  logic [cache_pkg::index_w-1:0]  lookup_index,
	input  logic [cache_pkg::tag_w-1:0]    lookup_tag,
	output logic                           hit,
	output logic                           victim_dirty,
	output logic [cache_pkg::tag_w-1:0]    victim_tag,
	output logic [cache_pkg::data_w-1:0]   victim_data,
	output logic [cache_pkg::data_w-1:0]   line_data,
	input  logic                           fill_en,
	input  logic [cache_pkg::tag_w-1:0]    fill_tag,
	input  logic [cache_pkg::data_w-1:0]   fill_data,
	input  logic                           fill_dirty
);

	logic [cache_pkg::lines-1:0] valid_q;
	logic [cache_pkg::lines-1:0] dirty_q;
	logic [cache_pkg::tag_w-1:0] tag_q [cache_pkg::lines];
	logic [cache_pkg::data_w-1:0] data_q [cache_pkg::lines];

	logic [cache_pkg::data_w-1:0] word;

	// selected line read straight off the arrays
	assign word = data_q[lookup_index];
	assign victim_tag = tag_q[lookup_index];
	assign hit = valid_q[lookup_index] && (victim_tag == lookup_tag);
	assign victim_dirty = valid_q[lookup_index] && dirty_q[lookup_index];

	// write-back source and read return are one word
	assign victim_data = word;
	assign line_data = word;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			valid_q <= '0;
			dirty_q <= '0;
		end
		else if (fill_en)
		begin
			valid_q[lookup_index] <= 1'b1;
			dirty_q[lookup_index] <= fill_dirty;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill_en)
		begin
			tag_q[lookup_index] <= fill_tag;
			data_q[lookup_index] <= fill_data;
		end
	end

endmodule

`default_nettype wire

/* verilog/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top
(
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             cpu_req,
	input  logic                             cpu_we,
	input  logic [cache_pkg::addr_w-1:0]     cpu_addr,
	input  logic [cache_pkg::data_w-1:0]     cpu_wdata,
	output logic                             cpu_ack,
	output logic [cache_pkg::data_w-1:0]     cpu_rdata,
	output logic                             mem_req,
	output logic                             mem_we,
	output logic [cache_pkg::addr_w-1:0]     mem_addr,
	output logic [cache_pkg::data_w-1:0]     mem_wdata,
	input  logic                             mem_ack,
	input  logic [cache_pkg::data_w-1:0]     mem_rdata,
	input  logic                             csr_req,
	input  logic                             csr_we,
	input  logic [cache_pkg::csr_sel_w-1:0]  csr_sel,
	input  logic [cache_pkg::data_w-1:0]     csr_wdata,
	output logic                             csr_ack,
	output logic [cache_pkg::data_w-1:0]     csr_rdata
);

	// controller to register block
	logic enable;
	logic hit_pulse;
	logic miss_pulse;

	// controller to store
	logic [cache_pkg::index_w-1:0] lookup_index;
	logic [cache_pkg::tag_w-1:0] lookup_tag;
	logic hit;
	logic victim_dirty;
	logic [cache_pkg::tag_w-1:0] victim_tag;
	logic [cache_pkg::data_w-1:0] victim_data;
	logic [cache_pkg::data_w-1:0] line_data;
	logic fill_en;
	logic [cache_pkg::tag_w-1:0] fill_tag;
	logic [cache_pkg::data_w-1:0] fill_data;
	logic fill_dirty;

	cache_ctrl i_ctrl (.*);

	cache_store i_store (.*);

	cache_csr i_csr (.*);

endmodule

`default_nettype wire
